/* all.f */
zx_cfg_pkg.sv
zx_mem_pkg.sv
z80_bus_if.sv
pager_cfg_if.sv
zport_decode.sv
atm_pager.sv
zdos.sv
zmem_map.sv
zx_pager_top.sv
tb_zx_pager.sv

/* atm_pager.sv */
`timescale 1ns/1ps

module atm_pager
#(
	parameter int WIN = 0
)
(
	input  logic                          fclk,
	input  logic                          rst,
	pager_cfg_if.pager                    cfg,
	input  zx_mem_pkg::dos_state_e        dos,
	output logic [zx_mem_pkg::PAGE_W-1:0] page,
	output logic                          rom
);

	logic [zx_mem_pkg::PAGE_W-1:0] page_r;
	logic                          rom_r;
	logic                          dos_bit;

	// stored ATM page for this window
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			page_r <= '0;
			rom_r  <= 1'b0;
		end
		else if (cfg.atm_wr[WIN])
		begin
			page_r <= cfg.wr_data;
			rom_r  <= cfg.wr_rom;
		end
	end

	assign dos_bit = (dos == zx_mem_pkg::dos_on);

	////////////////////////////////////////
	// effective page
	////////////////////////////////////////

	always_comb
	begin
		page = '0;
		rom  = 1'b0;
		if (!cfg.pager_off)
		begin
			rom = rom_r;
			// rom page bit 0 tracks DOS
			if (rom_r)
				page = {page_r[zx_mem_pkg::PAGE_W-1:1], dos_bit};
			else
				page = page_r;
		end
		else if (WIN == 0)
		begin
			rom     = 1'b1;
			page[1] = dos_bit;
			page[0] = cfg.pent_rom;
		end
		else if (WIN == 1)
			page = zx_mem_pkg::PENT_WIN1_PAGE;
		else if (WIN == 2)
			page = zx_mem_pkg::PENT_WIN2_PAGE;
		else
			page = {{(zx_mem_pkg::PAGE_W-3){1'b0}}, cfg.pent_bank};
	end

endmodule

/* pager_cfg_if.sv */
`timescale 1ns/1ps

interface pager_cfg_if;

	// page port write, one strobe per window
	logic [zx_mem_pkg::NUM_WIN-1:0] atm_wr;
	logic [zx_mem_pkg::PAGE_W-1:0]  wr_data;
	logic                           wr_rom;

	// global mode and 7FFD state
	logic       pager_off;
	logic       pent_rom;
	logic [2:0] pent_bank;

	modport decoder
	(
		output atm_wr,
		output wr_data,
		output wr_rom,
		output pager_off,
		output pent_rom,
		output pent_bank
	);

	modport pager
	(
		input atm_wr,
		input wr_data,
		input wr_rom,
		input pager_off,
		input pent_rom,
		input pent_bank
	);

endinterface

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_zx_pager -f all.f -o tb_zx_pager \
	&& ./obj_dir/tb_zx_pager \
	|| exit 1

/* tb_zx_pager.sv */
`timescale 1ns/1ps

module tb_zx_pager;

	localparam int RESET_CYCLES = 16;
	localparam int MARGIN       = 50;

	typedef enum logic [1:0]
	{
		io_write,
		mem_read,
		fetch
	} op_e;

	typedef struct packed
	{
		op_e                           op;
		logic [15:0]                   addr;
		logic [7:0]                    data;
		logic                          exp_rom;
		logic                          exp_ram;
		logic [zx_mem_pkg::PAGE_W-1:0] exp_page;
	} row_t;

	logic        fclk;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  d;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;

	logic                            rom_cs;
	logic                            ram_cs;
	logic [zx_mem_pkg::MEM_ADDR_W-1:0] mem_addr;

	row_t rows [$];
	int   cycles;
	int   cycle_limit;

	zx_pager_top UUT
	(
		.fclk     (fclk),
		.rst      (rst),
		.a        (a),
		.d        (d),
		.mreq_n   (mreq_n),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.rom_cs   (rom_cs),
		.ram_cs   (ram_cs),
		.mem_addr (mem_addr)
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	// run length guard
	initial
	begin
		cycles = 0;
	end

	always @(posedge fclk)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout, the run went past %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// flat address from page and offset
	function automatic logic [zx_mem_pkg::MEM_ADDR_W-1:0] expected_addr
	(
		input logic                          is_rom,
		input logic [zx_mem_pkg::PAGE_W-1:0] pg,
		input logic [zx_mem_pkg::OFS_W-1:0]  ofs
	);
		logic [zx_mem_pkg::MEM_ADDR_W-1:0] addr;
		addr = '0;
		addr[zx_mem_pkg::OFS_W-1:0] = ofs;
		if (is_rom)
			addr[zx_mem_pkg::OFS_W +: zx_mem_pkg::ROM_PAGE_W] = pg[zx_mem_pkg::ROM_PAGE_W-1:0];
		else
			addr[zx_mem_pkg::OFS_W +: zx_mem_pkg::RAM_PAGE_W] = pg[zx_mem_pkg::RAM_PAGE_W-1:0];
		return addr;
	endfunction

	task automatic add_row
	(
		input op_e         op,
		input logic [15:0] addr,
		input logic [7:0]  data,
		input logic        exp_rom,
		input logic        exp_ram,
		input logic [7:0]  exp_page
	);
		row_t r;
		r.op       = op;
		r.addr     = addr;
		r.data     = data;
		r.exp_rom  = exp_rom;
		r.exp_ram  = exp_ram;
		r.exp_page = exp_page;
		rows.push_back(r);
	endtask

	task automatic drive_idle();
		a      <= 16'h0000;
		d      <= 8'h00;
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
	endtask

	task automatic drive_row(input op_e op, input logic [15:0] addr, input logic [7:0] data);
		a      <= addr;
		d      <= data;
		mreq_n <= (op == io_write);
		iorq_n <= (op != io_write);
		rd_n   <= (op == io_write);
		wr_n   <= (op != io_write);
		m1_n   <= (op != fetch);
	endtask

	task automatic check_outputs
	(
		input logic                              exp_rom,
		input logic                              exp_ram,
		input logic [zx_mem_pkg::MEM_ADDR_W-1:0] exp_addr
	);
		assert (rom_cs === exp_rom)
		else
		begin
			$display("FAILED at %0t: rom_cs expected %0b, got %0b", $time, exp_rom, rom_cs);
			$display("RESULT: FAIL");
			$fatal(1, "rom_cs mismatch");
		end
		assert (ram_cs === exp_ram)
		else
		begin
			$display("FAILED at %0t: ram_cs expected %0b, got %0b", $time, exp_ram, ram_cs);
			$display("RESULT: FAIL");
			$fatal(1, "ram_cs mismatch");
		end
		assert (mem_addr === exp_addr)
		else
		begin
			$display("FAILED at %0t: mem_addr expected %06h, got %06h", $time, exp_addr,
				mem_addr);
			$display("RESULT: FAIL");
			$fatal(1, "mem_addr mismatch");
		end
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////

	task automatic build_table();
		// pentagon after reset
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h00);
		add_row(mem_read, 16'h4000, 8'h00, 1'b0, 1'b1, 8'h05);
		add_row(mem_read, 16'h8000, 8'h00, 1'b0, 1'b1, 8'h02);
		add_row(mem_read, 16'hC000, 8'h00, 1'b0, 1'b1, 8'h00);
		// 7FFD bank 3 and rom 1
		add_row(io_write, 16'h7FFD, 8'h13, 1'b0, 1'b0, 8'h00);
		add_row(mem_read, 16'hC000, 8'h00, 1'b0, 1'b1, 8'h03);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h01);
		// bank 6 and rom 0, then locked
		add_row(io_write, 16'h7FFD, 8'h26, 1'b0, 1'b0, 8'h00);
		add_row(mem_read, 16'hC000, 8'h00, 1'b0, 1'b1, 8'h06);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h00);
		add_row(io_write, 16'h7FFD, 8'h11, 1'b0, 1'b0, 8'h00);
		add_row(mem_read, 16'hC000, 8'h00, 1'b0, 1'b1, 8'h06);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h00);
		// DOS on at 3Dxx and off above 8000
		add_row(fetch,    16'h3D00, 8'h00, 1'b1, 1'b0, 8'h02);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h02);
		add_row(fetch,    16'h8000, 8'h00, 1'b0, 1'b1, 8'h02);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h00);
		// ATM mode with pages still zero
		add_row(io_write, 16'h0077, 8'h00, 1'b0, 1'b0, 8'h00);
		add_row(mem_read, 16'h0000, 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(io_write, 16'h08F7, 8'h04, 1'b0, 1'b0, 8'h00);
		add_row(io_write, 16'h40F7, 8'h21, 1'b0, 1'b0, 8'h00);
		add_row(io_write, 16'h80F7, 8'h45, 1'b0, 1'b0, 8'h00);
		add_row(io_write, 16'hC0F7, 8'hFE, 1'b0, 1'b0, 8'h00);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h04);
		add_row(mem_read, 16'h4000, 8'h00, 1'b0, 1'b1, 8'h21);
		add_row(mem_read, 16'h8000, 8'h00, 1'b0, 1'b1, 8'h45);
		add_row(mem_read, 16'hC000, 8'h00, 1'b0, 1'b1, 8'hFE);
		// rom page bit 0 follows DOS
		add_row(fetch,    16'h3D00, 8'h00, 1'b1, 1'b0, 8'h05);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h05);
		add_row(fetch,    16'hC000, 8'h00, 1'b0, 1'b1, 8'hFE);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h04);
		// back to pentagon with 7FFD = 26
		add_row(io_write, 16'h0077, 8'h01, 1'b0, 1'b0, 8'h00);
		add_row(mem_read, 16'h0000, 8'h00, 1'b1, 1'b0, 8'h00);
		add_row(mem_read, 16'hC000, 8'h00, 1'b0, 1'b1, 8'h06);
		add_row(mem_read, 16'h4000, 8'h00, 1'b0, 1'b1, 8'h05);
		add_row(mem_read, 16'h8000, 8'h00, 1'b0, 1'b1, 8'h02);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0]                       rnd;
		logic [15:0]                       addr;
		logic [zx_mem_pkg::MEM_ADDR_W-1:0] exp_addr;

		rnd = 32'hbdc9ca53;
		rst <= 1'b1;
		drive_idle();
		build_table();
		cycle_limit = RESET_CYCLES + 3 * rows.size() + MARGIN;

		repeat (RESET_CYCLES) @(posedge fclk);
		rst <= 1'b0;

		for (int i = 0; i < rows.size(); i++)
		begin
			rnd  = xorshift32(rnd);
			addr = rows[i].addr;
			// fetches keep the high byte for DOS decode
			if (rows[i].op == mem_read)
				addr[zx_mem_pkg::OFS_W-1:0] = rnd[zx_mem_pkg::OFS_W-1:0];
			else if (rows[i].op == fetch)
				addr[7:0] = rnd[7:0];

			if (rows[i].op == io_write)
				exp_addr = '0;
			else
				exp_addr = expected_addr(rows[i].exp_rom, rows[i].exp_page,
					addr[zx_mem_pkg::OFS_W-1:0]);

			@(posedge fclk);
			drive_row(rows[i].op, addr, rows[i].data);
			@(posedge fclk);
			@(negedge fclk);
			check_outputs(rows[i].exp_rom, rows[i].exp_ram, exp_addr);

			@(posedge fclk);
			drive_idle();
			@(negedge fclk);
			check_outputs(1'b0, 1'b0, '0);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* z80_bus_if.sv */
`timescale 1ns/1ps

interface z80_bus_if;

	// address and data
	logic [15:0] a;
	logic [7:0]  d;

	// control strobes, all active low
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;

	// observers only, the bus is driven at the top
	modport monitor
	(
		input a,
		input d,
		input mreq_n,
		input iorq_n,
		input rd_n,
		input wr_n,
		input m1_n
	);

endinterface

/* zdos.sv */
`timescale 1ns/1ps

module zdos
(
	input  logic                   fclk,
	input  logic                   rst,
	z80_bus_if.monitor             bus,
	input  logic                   win0_rom,
	output zx_mem_pkg::dos_state_e dos
);

	logic fetch;
	logic fetch_d;
	logic fetch_ev;
	logic turn_on;
	logic turn_off;

	zx_mem_pkg::dos_state_e state;

	// opcode fetch seen on its first edge only
	assign fetch    = !bus.mreq_n && !bus.m1_n && !bus.rd_n;
	assign fetch_ev = fetch && !fetch_d;

	assign turn_on  = fetch_ev && win0_rom && (bus.a[15:8] == zx_mem_pkg::DOS_ENTRY_HI);
	assign turn_off = fetch_ev && (bus.a[15:14] != 2'b00);

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			fetch_d <= 1'b0;
			state   <= zx_mem_pkg::dos_off;
		end
		else
		begin
			fetch_d <= fetch;
			if (turn_on)
				state <= zx_mem_pkg::dos_on;
			else if (turn_off)
				state <= zx_mem_pkg::dos_off;
		end
	end

	assign dos = state;

	// DOS comes on only after a fetch with window 0 in ROM
	a_dos_entry: assert property (@(posedge fclk) disable iff (rst)
		$rose(state == zx_mem_pkg::dos_on) |-> $past(fetch_ev && win0_rom));

endmodule

/* zmem_map.sv */
`timescale 1ns/1ps

module zmem_map
(
	z80_bus_if.monitor                          bus,
	input  logic [zx_mem_pkg::PAGE_W-1:0]       page [zx_mem_pkg::NUM_WIN],
	input  logic [zx_mem_pkg::NUM_WIN-1:0]      rom,
	output logic                                rom_cs,
	output logic                                ram_cs,
	output logic [zx_mem_pkg::MEM_ADDR_W-1:0]   mem_addr
);

	localparam int ROM_PAD = zx_mem_pkg::MEM_ADDR_W - zx_mem_pkg::ROM_PAGE_W
		- zx_mem_pkg::OFS_W;

	logic                          mem_cyc;
	logic [zx_mem_pkg::WIN_W-1:0]  win;
	logic [zx_mem_pkg::OFS_W-1:0]  ofs;
	logic [zx_mem_pkg::PAGE_W-1:0] sel_page;

	assign mem_cyc  = !bus.mreq_n && (!bus.rd_n || !bus.wr_n);
	assign win      = bus.a[15:14];
	assign ofs      = bus.a[zx_mem_pkg::OFS_W-1:0];
	assign sel_page = page[win];

	always_comb
	begin
		rom_cs   = 1'b0;
		ram_cs   = 1'b0;
		mem_addr = '0;
		if (mem_cyc)
		begin
			if (rom[win])
			begin
				rom_cs   = 1'b1;
				mem_addr = {{ROM_PAD{1'b0}}, sel_page[zx_mem_pkg::ROM_PAGE_W-1:0], ofs};
			end
			else
			begin
				ram_cs   = 1'b1;
				mem_addr = {sel_page[zx_mem_pkg::RAM_PAGE_W-1:0], ofs};
			end
		end
	end

endmodule

/* zport_decode.sv */
`timescale 1ns/1ps

module zport_decode
(
	input logic             fclk,
	input logic             rst,
	z80_bus_if.monitor      bus,
	pager_cfg_if.decoder    cfg
);

	logic io_wr;
	logic io_wr_d;
	logic io_ev;

	zx_cfg_pkg::port_kind_e kind;

	logic [7:0] reg_7ffd;
	logic       pager_off_r;

	logic [zx_mem_pkg::WIN_W-1:0] win_sel;

	////////////////////////////////////////
	// i/o write event
	////////////////////////////////////////

	assign io_wr = !bus.iorq_n && !bus.wr_n && bus.m1_n;
	assign io_ev = io_wr && !io_wr_d;

	always_ff @(posedge fclk)
	begin
		if (rst)
			io_wr_d <= 1'b0;
		else
			io_wr_d <= io_wr;
	end

	// 7FFD is only partially decoded
	always_comb
	begin
		kind = zx_cfg_pkg::none;
		if (io_ev)
		begin
			if (!bus.a[15] && !bus.a[1])
				kind = zx_cfg_pkg::p7ffd;
			else if (bus.a[7:0] == zx_cfg_pkg::PORT_ATM_CFG_LO)
				kind = zx_cfg_pkg::atm_cfg;
			else if (bus.a[7:0] == zx_cfg_pkg::PORT_ATM_PAGE_LO)
				kind = zx_cfg_pkg::atm_page;
		end
	end

	////////////////////////////////////////
	// config registers
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			reg_7ffd    <= 8'h00;
			pager_off_r <= zx_cfg_pkg::PAGER_OFF_RST;
		end
		else
		begin
			// lock holds until reset
			if (kind == zx_cfg_pkg::p7ffd && !reg_7ffd[zx_cfg_pkg::P7FFD_LOCK_BIT])
				reg_7ffd <= bus.d;
			if (kind == zx_cfg_pkg::atm_cfg)
				pager_off_r <= bus.d[0];
		end
	end

	// page write strobe per window from a15..a14
	assign win_sel = bus.a[15:14];

	always_comb
	begin
		cfg.atm_wr = '0;
		if (kind == zx_cfg_pkg::atm_page)
			cfg.atm_wr[win_sel] = 1'b1;
	end

	assign cfg.wr_data   = bus.d;
	assign cfg.wr_rom    = bus.a[11];
	assign cfg.pager_off = pager_off_r;
	assign cfg.pent_rom  = reg_7ffd[zx_cfg_pkg::P7FFD_ROM_BIT];
	assign cfg.pent_bank = reg_7ffd[2:0];

	// a locked 7FFD never changes until reset
	a_lock_holds: assert property (@(posedge fclk) disable iff (rst)
		reg_7ffd[zx_cfg_pkg::P7FFD_LOCK_BIT] |=> $stable(reg_7ffd));

endmodule

/* zx_cfg_pkg.sv */
package zx_cfg_pkg;

	////////////////////////////////////////
	// paging port decode
	////////////////////////////////////////

	// kind of i/o write seen on the bus
	typedef enum logic [1:0]
	{
		none,
		p7ffd,
		atm_cfg,
		atm_page
	} port_kind_e;

	// low address bytes of the ATM ports
	localparam logic [7:0] PORT_ATM_PAGE_LO = 8'hF7;
	localparam logic [7:0] PORT_ATM_CFG_LO  = 8'h77;

	// 7FFD bit positions
	localparam int P7FFD_LOCK_BIT = 5;
	localparam int P7FFD_ROM_BIT  = 4;

	////////////////////////////////////////
	// configuration after reset
	////////////////////////////////////////

	// pentagon mapping until the ATM config port is written
	localparam logic PAGER_OFF_RST = 1'b1;

endpackage

/* zx_mem_pkg.sv */
package zx_mem_pkg;

	////////////////////////////////////////
	// window and address geometry
	////////////////////////////////////////

	localparam int NUM_WIN = 4;
	localparam int WIN_W   = 2;
	localparam int OFS_W   = 14;

	// page register and the part of it that reaches the chips
	localparam int PAGE_W     = 8;
	localparam int ROM_PAGE_W = 5;
	localparam int RAM_PAGE_W = 7;

	// flat address, 2 MB of RAM
	localparam int MEM_ADDR_W = 21;

	////////////////////////////////////////
	// pentagon fixed pages
	////////////////////////////////////////

	localparam logic [PAGE_W-1:0] PENT_WIN1_PAGE = 8'd5;
	localparam logic [PAGE_W-1:0] PENT_WIN2_PAGE = 8'd2;

	////////////////////////////////////////
	// DOS control
	////////////////////////////////////////

	// fetch from 3Dxx switches TR-DOS in
	localparam logic [7:0] DOS_ENTRY_HI = 8'h3D;

	typedef enum logic
	{
		dos_off,
		dos_on
	} dos_state_e;

endpackage

/* zx_pager_top.sv */
`timescale 1ns/1ps

module zx_pager_top
(
	input  logic                                fclk,
	input  logic                                rst,
	input  logic [15:0]                         a,
	input  logic [7:0]                          d,
	input  logic                                mreq_n,
	input  logic                                iorq_n,
	input  logic                                rd_n,
	input  logic                                wr_n,
	input  logic                                m1_n,
	output logic                                rom_cs,
	output logic                                ram_cs,
	output logic [zx_mem_pkg::MEM_ADDR_W-1:0]   mem_addr
);

	z80_bus_if   bus ();
	pager_cfg_if cfg ();

	logic [zx_mem_pkg::PAGE_W-1:0]  page [zx_mem_pkg::NUM_WIN];
	logic [zx_mem_pkg::NUM_WIN-1:0] win_rom;
	zx_mem_pkg::dos_state_e         dos;

	assign bus.a      = a;
	assign bus.d      = d;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;

	zport_decode u_ports (.fclk(fclk), .rst(rst), .bus(bus), .cfg(cfg));

	////////////////////////////////////////
	// window pagers
	////////////////////////////////////////

	for (genvar i = 0; i < zx_mem_pkg::NUM_WIN; i++)
	begin : g_pager
		atm_pager #(.WIN(i)) u_pager
		(
			.fclk (fclk),
			.rst  (rst),
			.cfg  (cfg),
			.dos  (dos),
			.page (page[i]),
			.rom  (win_rom[i])
		);
	end

	zdos u_dos (.fclk(fclk), .rst(rst), .bus(bus), .win0_rom(win_rom[0]), .dos(dos));

	zmem_map u_map
	(
		.bus      (bus),
		.page     (page),
		.rom      (win_rom),
		.rom_cs   (rom_cs),
		.ram_cs   (ram_cs),
		.mem_addr (mem_addr)
	);

endmodule
